// ==== files.f ====
design/rvv_alu_pkg.sv
design/rvv_uop_queue.sv
design/rvv_alu_addsub.sv
design/rvv_alu_shift.sv
design/rvv_alu_unit.sv
design/rvv_alu_cluster.sv
design/rvv_rob.sv
design/rvv_alu_top.sv
tests/rvv_alu_tb.sv

// ==== tests/rvv_alu_tb.sv ====
// keeps at most ROB_DEPTH uops outstanding, so the queue never fills; expects VLEN of 64
`default_nettype none

module rvv_alu_tb;

  import rvv_alu_pkg::*;

  localparam int NUM_ROWS        = 16;
  localparam int NUM_RAND        = 24;
  localparam int HOLD_CYCLES     = 30;
  localparam int RESET_CYCLES    = 8;
  localparam int WATCHDOG_CYCLES = (NUM_ROWS + NUM_RAND) * 40 + HOLD_CYCLES + RESET_CYCLES;

  typedef struct packed {
    alu_op_e         op;
    sew_e            sew;
    logic [VLEN-1:0] vs2;
    logic [VLEN-1:0] vs1;
    logic [VLEN-1:0] vd;
  } row_t;

  // op, sew, vs2, vs1, expected vd
  localparam row_t ROWS [NUM_ROWS] = '{
    '{OP_ADD, SEW8,  64'h01FF_80FF_7F00_FF01, 64'h0101_8001_0100_0101, 64'h0200_0000_8000_0002},
    '{OP_ADD, SEW16, 64'hFFFF_00FF_8000_1234, 64'h0001_0001_8000_1111, 64'h0000_0100_0000_2345},
    '{OP_ADD, SEW32, 64'hFFFF_FFFF_0000_FFFF, 64'h0000_0001_0000_0001, 64'h0000_0000_0001_0000},
    '{OP_SUB, SEW8,  64'h0000_0180_0510_FF7F, 64'h0100_0201_0520_0180, 64'hFF00_FF7F_00F0_FEFF},
    '{OP_SUB, SEW16, 64'h0000_0100_8000_1234, 64'h0001_0001_0001_1234, 64'hFFFF_00FF_7FFF_0000},
    '{OP_SUB, SEW32, 64'h0000_0000_0000_0000, 64'h0000_0001_FFFF_FFFF, 64'hFFFF_FFFF_0000_0001},
    '{OP_SLL, SEW8,  64'h8181_8181_8181_8181, 64'h0001_0203_0809_0A0F, 64'h8102_0408_8102_0480},
    '{OP_SRL, SEW8,  64'h8080_8080_F0F0_F0F0, 64'h0001_0407_0809_0C0F, 64'h8040_0801_F078_0F01},
    '{OP_SRA, SEW8,  64'h8080_8080_F0F0_F0F0, 64'h0001_0407_0809_0C0F, 64'h80C0_F8FF_F0F8_FFFF},
    '{OP_SRA, SEW16, 64'h8000_7FFF_F00F_1234, 64'h0004_0001_0013_0010, 64'hF800_3FFF_FE01_1234},
    '{OP_SRL, SEW32, 64'h8000_0000_FFFF_FFFF, 64'h0000_001F_0000_0024, 64'h0000_0001_0FFF_FFFF},
    '{OP_SLL, SEW32, 64'h0000_0001_1234_5678, 64'h0000_0020_0000_0004, 64'h0000_0001_2345_6780},
    '{OP_SLL, SEW16, 64'h0001_8001_00FF_1234, 64'h000F_0001_0018_0004, 64'h8000_0002_FF00_2340},
    '{OP_AND, SEW8,  64'hF0F0_FF00_AAAA_1234, 64'h0FF0_F0F0_5555_FFFF, 64'h00F0_F000_0000_1234},
    '{OP_OR,  SEW16, 64'hF000_0F00_00F0_000F, 64'h0000_1000_0100_0010, 64'hF000_1F00_01F0_001F},
    '{OP_XOR, SEW32, 64'hFFFF_0000_1234_5678, 64'hFFFF_FFFF_1234_0000, 64'h0000_FFFF_0000_5678}
  };

  localparam string ROW_NAME [NUM_ROWS] = '{
    "add8_carry", "add16_carry", "add32_carry", "sub8_borrow", "sub16_borrow",
    "sub32_borrow", "sll8_low_bits", "srl8_zero_fill", "sra8_sign_fill", "sra16_low_bits",
    "srl32_low_bits", "sll32_low_bits", "sll16_low_bits", "and8", "or16", "xor32"
  };

  logic                 clk;
  logic                 rst_n;
  logic                 push;
  alu_uop_t             push_uop;
  logic                 full;
  logic                 retire_valid;
  logic                 retire_ready;
  logic [ROB_IDX_W-1:0] retire_idx;
  vreg_u                retire_vd;

  // scoreboard, one entry per pushed uop in push order
  logic [ROB_IDX_W-1:0] sb_idx [$];
  logic [VLEN-1:0]      sb_vd [$];
  string                sb_name [$];

  logic [ROB_IDX_W-1:0] next_idx;
  logic [15:0]          lfsr;
  int                   n_pushed;
  int                   n_retired;
  int                   n_pass;
  int                   n_fail;

  rvv_alu_top UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .push         (push),
    .push_uop     (push_uop),
    .full         (full),
    .retire_valid (retire_valid),
    .retire_ready (retire_ready),
    .retire_idx   (retire_idx),
    .retire_vd    (retire_vd)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // fibonacci lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one lfsr step per bit taken
  task automatic take_bits(input int n, output logic [VLEN-1:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[VLEN-2:0], lfsr[15]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // per-element reference, each element wraps at its own width
  function automatic logic [VLEN-1:0] model_vd(input alu_op_e op, input sew_e sew,
                                               input logic [VLEN-1:0] a,
                                               input logic [VLEN-1:0] b);
    int              w;
    int              sh;
    logic [VLEN-1:0] mask;
    logic [VLEN-1:0] ea;
    logic [VLEN-1:0] eb;
    logic [VLEN-1:0] sx;
    logic [VLEN-1:0] r;
    logic [VLEN-1:0] vd;
    w    = (sew == SEW8) ? 8 : ((sew == SEW16) ? 16 : 32);
    mask = (64'd1 << w) - 64'd1;
    vd   = '0;
    for (int k = 0; k < VLEN / w; k++) begin
      ea = (a >> (k * w)) & mask;
      eb = (b >> (k * w)) & mask;
      // shift amount is the low log2(sew) bits
      sh = int'(eb % w);
      // sign extended copy for sra
      sx = ea[w-1] ? (ea | ~mask) : ea;
      case (op)
        OP_ADD:  r = ea + eb;
        OP_SUB:  r = ea - eb;
        OP_SLL:  r = ea << sh;
        OP_SRL:  r = ea >> sh;
        OP_SRA:  r = $signed(sx) >>> sh;
        OP_AND:  r = ea & eb;
        OP_OR:   r = ea | eb;
        default: r = ea ^ eb;
      endcase
      vd = vd | ((r & mask) << (k * w));
    end
    return vd;
  endfunction

  task automatic new_random_uop(output alu_op_e op, output sew_e sew,
                                output logic [VLEN-1:0] vs2, output logic [VLEN-1:0] vs1);
    logic [VLEN-1:0] r;
    take_bits(3, r);
    op = alu_op_e'(r[2:0]);
    take_bits(2, r);
    sew = (r[1:0] == 2'd0) ? SEW8 : ((r[1:0] == 2'd1) ? SEW16 : SEW32);
    take_bits(VLEN, vs2);
    take_bits(VLEN, vs1);
  endtask

  // drive one push this cycle, tag is the next rob index
  task automatic issue_uop(input string name, input alu_op_e op, input sew_e sew,
                           input logic [VLEN-1:0] vs2, input logic [VLEN-1:0] vs1,
                           input logic [VLEN-1:0] vd);
    alu_uop_t u;
    u.op      = op;
    u.sew     = sew;
    u.vs2     = vs2;
    u.vs1     = vs1;
    u.rob_idx = next_idx;
    push     <= 1'b1;
    push_uop <= u;
    sb_idx.push_back(next_idx);
    sb_vd.push_back(vd);
    sb_name.push_back(name);
    next_idx = next_idx + 1'b1;
    n_pushed++;
  endtask

  // wait for a free rob slot, then push and step one edge
  task automatic issue_when_free(input string name, input alu_op_e op, input sew_e sew,
                                 input logic [VLEN-1:0] vs2, input logic [VLEN-1:0] vs1,
                                 input logic [VLEN-1:0] vd);
    while (n_pushed - n_retired >= ROB_DEPTH) begin
      push <= 1'b0;
      @(posedge clk);
    end
    issue_uop(name, op, sew, vs2, vs1, vd);
    @(posedge clk);
  endtask

  task automatic check_retire();
    logic [ROB_IDX_W-1:0] exp_idx;
    logic [VLEN-1:0]      exp_vd;
    string                name;
    if (sb_idx.size() == 0) begin
      $display("ERROR: rob index %0d retired with no uop outstanding", retire_idx);
      n_fail++;
    end else begin
      exp_idx = sb_idx.pop_front();
      exp_vd  = sb_vd.pop_front();
      name    = sb_name.pop_front();
      if (retire_idx != exp_idx) begin
        $display("FAILED %s retire_idx expected %0d actual %0d", name, exp_idx, retire_idx);
        n_fail++;
      end else if (retire_vd != exp_vd) begin
        $display("FAILED %s vd expected %h actual %h", name, exp_vd, retire_vd);
        n_fail++;
      end else begin
        $display("ok     %s idx %0d vd %h", name, retire_idx, retire_vd);
        n_pass++;
      end
      n_retired++;
    end
  endtask

  // handshake seen at negedge completes on the next rising edge
  always @(negedge clk) begin
    if (rst_n && retire_valid && retire_ready) begin
      check_retire();
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("ERROR: run hung, only %0d of %0d uops retired", n_retired, n_pushed);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    alu_op_e         op;
    sew_e            sew;
    logic [VLEN-1:0] a;
    logic [VLEN-1:0] b;
    int              n_rand;
    rst_n        = 1'b0;
    push         = 1'b0;
    push_uop     = '0;
    retire_ready = 1'b1;
    next_idx     = '0;
    lfsr         = 16'd30;
    n_pushed     = 0;
    n_retired    = 0;
    n_pass       = 0;
    n_fail       = 0;
    n_rand       = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (retire_valid !== 1'b0 || full !== 1'b0) begin
      $display("FAILED reset_state expected 00 actual %b%b", retire_valid, full);
      n_fail++;
    end else begin
      $display("ok     reset_state");
      n_pass++;
    end
    @(posedge clk);
    // directed rows, pushed back to back
    for (int r = 0; r < NUM_ROWS; r++) begin
      issue_when_free(ROW_NAME[r], ROWS[r].op, ROWS[r].sew, ROWS[r].vs2, ROWS[r].vs1,
                      ROWS[r].vd);
    end
    // retire held off, pushes fill the rob
    retire_ready <= 1'b0;
    for (int h = 0; h < HOLD_CYCLES; h++) begin
      if (n_rand < NUM_RAND && (n_pushed - n_retired) < ROB_DEPTH) begin
        new_random_uop(op, sew, a, b);
        issue_uop($sformatf("rand_%0d", n_rand), op, sew, a, b, model_vd(op, sew, a, b));
        n_rand++;
      end else begin
        push <= 1'b0;
      end
      @(posedge clk);
    end
    retire_ready <= 1'b1;
    while (n_rand < NUM_RAND) begin
      new_random_uop(op, sew, a, b);
      issue_when_free($sformatf("rand_%0d", n_rand), op, sew, a, b, model_vd(op, sew, a, b));
      n_rand++;
    end
    push <= 1'b0;
    while (n_retired < n_pushed) @(posedge clk);
    // a few idle edges to catch a duplicated retire
    repeat (4) @(posedge clk);
    $display("tests: %0d passed, %0d failed, %0d uops retired", n_pass, n_fail, n_retired);
    if (n_fail == 0 && sb_idx.size() == 0 && n_retired == NUM_ROWS + NUM_RAND) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/rvv_alu_top.sv ====
// push to earliest retire_valid takes two edges and grows under retire back-pressure
`default_nettype none

module rvv_alu_top (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              push,
  input  rvv_alu_pkg::alu_uop_t             push_uop,
  output logic                              full,
  output logic                              retire_valid,
  input  logic                              retire_ready,
  output logic [rvv_alu_pkg::ROB_IDX_W-1:0] retire_idx,
  output rvv_alu_pkg::vreg_u                retire_vd
);

  import rvv_alu_pkg::*;

  // queue to cluster
  alu_uop_t [NUM_ALU-1:0] q_uop;
  logic                   q_empty;
  logic [NUM_ALU-1:1]     q_almost_empty;
  logic [NUM_ALU-1:0]     pop;
  // cluster to rob
  logic [NUM_ALU-1:0]     res_valid;
  alu_res_t [NUM_ALU-1:0] res;
  logic [NUM_ALU-1:0]     res_ready;

  rvv_uop_queue u_queue (
    .clk          (clk),
    .rst_n        (rst_n),
    .push         (push),
    .push_uop     (push_uop),
    .full         (full),
    .uop          (q_uop),
    .empty        (q_empty),
    .almost_empty (q_almost_empty),
    .pop          (pop)
  );

  rvv_alu_cluster u_cluster (
    .uop          (q_uop),
    .empty        (q_empty),
    .almost_empty (q_almost_empty),
    .pop          (pop),
    .result_valid (res_valid),
    .result       (res),
    .result_ready (res_ready)
  );

  rvv_rob u_rob (
    .clk          (clk),
    .rst_n        (rst_n),
    .result_valid (res_valid),
    .result       (res),
    .result_ready (res_ready),
    .pop          (pop),
    .retire_valid (retire_valid),
    .retire_ready (retire_ready),
    .retire_idx   (retire_idx),
    .retire_vd    (retire_vd)
  );

endmodule

`default_nettype wire

// ==== design/rvv_rob.sv ====
// no more than ROB_DEPTH uops may be outstanding and each rob_idx is used once until retired
`default_nettype none

module rvv_rob (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic [rvv_alu_pkg::NUM_ALU-1:0]              result_valid,
  input  rvv_alu_pkg::alu_res_t [rvv_alu_pkg::NUM_ALU-1:0] result,
  output logic [rvv_alu_pkg::NUM_ALU-1:0]              result_ready,
  input  logic [rvv_alu_pkg::NUM_ALU-1:0]              pop,
  output logic                                         retire_valid,
  input  logic                                         retire_ready,
  output logic [rvv_alu_pkg::ROB_IDX_W-1:0]            retire_idx,
  output rvv_alu_pkg::vreg_u                           retire_vd
);

  import rvv_alu_pkg::*;

  // per-slot done flag and result data
  logic [ROB_DEPTH-1:0]  done;
  vreg_u                 data [ROB_DEPTH];
  logic [ROB_IDX_W-1:0]  head;
  logic [NUM_ALU-1:0]    wr_en;
  logic                  retire;

  // a lane writes exactly when it pops
  assign wr_en  = pop & result_valid;
  assign retire = retire_valid && retire_ready;

  // slot still holding an unretired result blocks its lane
  genvar i;
  generate
    for (i = 0; i < NUM_ALU; i++) begin : g_ready
      assign result_ready[i] = !done[result[i].rob_idx];
    end
  endgenerate

  // in-order retire from head
  assign retire_valid = done[head];
  assign retire_idx   = head;
  assign retire_vd    = data[head];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done <= '0;
      head <= '0;
    end else begin
      if (retire) begin
        done[head] <= 1'b0;
        head       <= head + 1'b1;
      end
      // a done head slot is never written, ready is low for it
      for (int k = 0; k < NUM_ALU; k++) begin
        if (wr_en[k]) begin
          done[result[k].rob_idx] <= 1'b1;
        end
      end
    end
  end

  // result data
  always_ff @(posedge clk) begin
    for (int k = 0; k < NUM_ALU; k++) begin
      if (wr_en[k]) begin
        data[result[k].rob_idx] <= result[k].vd;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/rvv_alu_cluster.sv ====
// lanes take the oldest uops in order and a stalled lane blocks every lane above it
`default_nettype none

module rvv_alu_cluster (
  input  rvv_alu_pkg::alu_uop_t [rvv_alu_pkg::NUM_ALU-1:0] uop,
  input  logic                                         empty,
  input  logic [rvv_alu_pkg::NUM_ALU-1:1]              almost_empty,
  output logic [rvv_alu_pkg::NUM_ALU-1:0]              pop,
  output logic [rvv_alu_pkg::NUM_ALU-1:0]              result_valid,
  output rvv_alu_pkg::alu_res_t [rvv_alu_pkg::NUM_ALU-1:0] result,
  input  logic [rvv_alu_pkg::NUM_ALU-1:0]              result_ready
);

  import rvv_alu_pkg::*;

  logic [NUM_ALU-1:0] lane_valid;

  // lane 0 only needs a non-empty queue
  assign lane_valid[0] = !empty;
  assign pop[0]        = lane_valid[0] & result_valid[0] & result_ready[0];

  genvar i;
  generate
    for (i = 1; i < NUM_ALU; i++) begin : g_lane_ctl
      // lane i needs more than i entries
      assign lane_valid[i] = !(empty || (|almost_empty[i:1]));
      // thermometer pop, every lower lane must pop too
      assign pop[i] = lane_valid[i] & result_valid[i] & result_ready[i] & (&pop[i-1:0]);
    end
  endgenerate

  generate
    for (i = 0; i < NUM_ALU; i++) begin : g_alu
      rvv_alu_unit u_alu_unit (
        .alu_uop_valid (lane_valid[i]),
        .alu_uop       (uop[i]),
        .result_valid  (result_valid[i]),
        .result        (result[i])
      );
    end
  endgenerate

endmodule

`default_nettype wire

// ==== design/rvv_alu_unit.sv ====
// purely combinational lane, the result is valid in the same cycle as the uop
`default_nettype none

module rvv_alu_unit (
  input  logic                   alu_uop_valid,
  input  rvv_alu_pkg::alu_uop_t  alu_uop,
  output logic                   result_valid,
  output rvv_alu_pkg::alu_res_t  result
);

  import rvv_alu_pkg::*;

  logic            is_sub;
  logic            sel_addsub;
  logic            sel_shift;
  vreg_u           sum;
  vreg_u           shift_res;
  logic [VLEN-1:0] logic_res;

  // sub-unit selects
  always_comb begin
    is_sub     = 1'b0;
    sel_addsub = 1'b0;
    sel_shift  = 1'b0;
    case (alu_uop.op)
      OP_ADD: sel_addsub = 1'b1;
      OP_SUB: begin
        sel_addsub = 1'b1;
        is_sub     = 1'b1;
      end
      OP_SLL, OP_SRL, OP_SRA: sel_shift = 1'b1;
      default: ;
    endcase
  end

  // bitwise ops ignore sew
  always_comb begin
    case (alu_uop.op)
      OP_AND:  logic_res = alu_uop.vs2 & alu_uop.vs1;
      OP_OR:   logic_res = alu_uop.vs2 | alu_uop.vs1;
      default: logic_res = alu_uop.vs2 ^ alu_uop.vs1;
    endcase
  end

  rvv_alu_addsub u_addsub (
    .a   (alu_uop.vs2),
    .b   (alu_uop.vs1),
    .sub (is_sub),
    .sew (alu_uop.sew),
    .sum (sum)
  );

  // vs1 carries the per-element shift amounts
  rvv_alu_shift u_shift (
    .a   (alu_uop.vs2),
    .amt (alu_uop.vs1),
    .op  (alu_uop.op),
    .sew (alu_uop.sew),
    .res (shift_res)
  );

  assign result_valid = alu_uop_valid;

  always_comb begin
    result.rob_idx = alu_uop.rob_idx;
    if (sel_addsub) begin
      result.vd = sum;
    end else if (sel_shift) begin
      result.vd = shift_res;
    end else begin
      result.vd = logic_res;
    end
  end

endmodule

`default_nettype wire

// ==== design/rvv_alu_shift.sv ====
// only the low log2(SEW) bits of each vs1 element set its shift amount
`default_nettype none

module rvv_alu_shift (
  input  rvv_alu_pkg::vreg_u    a,
  input  rvv_alu_pkg::vreg_u    amt,
  input  rvv_alu_pkg::alu_op_e  op,
  input  rvv_alu_pkg::sew_e     sew,
  output rvv_alu_pkg::vreg_u    res
);

  import rvv_alu_pkg::*;

  vreg_u res8;
  vreg_u res16;
  vreg_u res32;
  logic  right;
  logic  arith;

  assign right = (op == OP_SRL) || (op == OP_SRA);
  // srl shares the sra shifter with a zero fill bit
  assign arith = (op == OP_SRA);

  always_comb begin
    logic signed [8:0]  x8;
    logic signed [16:0] x16;
    logic signed [32:0] x32;
    // bytes
    for (int k = 0; k < NUM_B; k++) begin
      x8          = {arith & a.e8[k][7], a.e8[k]};
      x8          = x8 >>> amt.e8[k][2:0];
      res8.e8[k]  = right ? x8[7:0] : (a.e8[k] << amt.e8[k][2:0]);
    end
    // halfwords
    for (int k = 0; k < NUM_H; k++) begin
      x16          = {arith & a.e16[k][15], a.e16[k]};
      x16          = x16 >>> amt.e16[k][3:0];
      res16.e16[k] = right ? x16[15:0] : (a.e16[k] << amt.e16[k][3:0]);
    end
    // words
    for (int k = 0; k < NUM_W; k++) begin
      x32          = {arith & a.e32[k][31], a.e32[k]};
      x32          = x32 >>> amt.e32[k][4:0];
      res32.e32[k] = right ? x32[31:0] : (a.e32[k] << amt.e32[k][4:0]);
    end
  end

  always_comb begin
    case (sew)
      SEW8:    res = res8;
      SEW16:   res = res16;
      default: res = res32;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/rvv_alu_addsub.sv ====
// results wrap within each element, no carry or borrow crosses an element boundary
`default_nettype none

module rvv_alu_addsub (
  input  rvv_alu_pkg::vreg_u a,
  input  rvv_alu_pkg::vreg_u b,
  input  logic               sub,
  input  rvv_alu_pkg::sew_e  sew,
  output rvv_alu_pkg::vreg_u sum
);

  import rvv_alu_pkg::*;

  logic [NUM_B-1:0][7:0] b_eff;
  logic [NUM_B-1:0]      elem_base;

  // subtract as a + ~b + 1
  assign b_eff = sub ? ~b.e8 : b.e8;

  // bytes that start an element under the current sew
  always_comb begin
    for (int j = 0; j < NUM_B; j++) begin
      case (sew)
        SEW8:    elem_base[j] = 1'b1;
        SEW16:   elem_base[j] = ((j % 2) == 0);
        default: elem_base[j] = ((j % 4) == 0);
      endcase
    end
  end

  // row of 8-bit adders, carry cut at each element base
  always_comb begin
    logic       cin;
    logic [8:0] s;
    cin = sub;
    for (int j = 0; j < NUM_B; j++) begin
      // the +1 of a subtract enters here
      if (elem_base[j]) begin
        cin = sub;
      end
      s          = {1'b0, a.e8[j]} + {1'b0, b_eff[j]} + {8'd0, cin};
      sum.e8[j]  = s[7:0];
      // chain into the next byte of a wider element
      cin        = s[8];
    end
  end

endmodule

`default_nettype wire

// ==== design/rvv_uop_queue.sv ====
// a push while full is dropped, and pop must be thermometer shaped and never exceed the count
`default_nettype none

module rvv_uop_queue (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic                                         push,
  input  rvv_alu_pkg::alu_uop_t                        push_uop,
  output logic                                         full,
  output rvv_alu_pkg::alu_uop_t [rvv_alu_pkg::NUM_ALU-1:0] uop,
  output logic                                         empty,
  output logic [rvv_alu_pkg::NUM_ALU-1:1]              almost_empty,
  input  logic [rvv_alu_pkg::NUM_ALU-1:0]              pop
);

  import rvv_alu_pkg::*;

  // entry storage
  alu_uop_t          mem [QUEUE_DEPTH];
  logic [QPTR_W-1:0] head;
  logic [QPTR_W-1:0] tail;
  logic [QCNT_W-1:0] count;
  logic [QCNT_W-1:0] n_pop;
  logic              push_ok;

  assign push_ok = push && !full;
  assign full    = (count == QCNT_W'(QUEUE_DEPTH));
  assign empty   = (count == '0);

  // number of entries leaving this cycle
  always_comb begin
    n_pop = '0;
    for (int i = 0; i < NUM_ALU; i++) begin
      n_pop = n_pop + QCNT_W'(pop[i]);
    end
  end

  // bit i set means i or fewer entries held
  always_comb begin
    almost_empty = '1;
    for (int i = 1; i < NUM_ALU; i++) begin
      almost_empty[i] = (count <= QCNT_W'(i));
    end
  end

  // read port i shows entry head+i as the pointer wraps
  genvar g;
  generate
    for (g = 0; g < NUM_ALU; g++) begin : g_rd
      assign uop[g] = mem[head + QPTR_W'(g)];
    end
  endgenerate

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push_ok) begin
        tail <= tail + 1'b1;
      end
      // thermometer pop moves head by the number of set bits
      head  <= head + n_pop[QPTR_W-1:0];
      count <= count + QCNT_W'(push_ok) - n_pop;
    end
  end

  // payload write
  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[tail] <= push_uop;
    end
  end

endmodule

`default_nettype wire

// ==== design/rvv_alu_pkg.sv ====
// QUEUE_DEPTH must be a power of two, ROB_DEPTH must equal 2**ROB_IDX_W, VLEN a multiple of 32
`default_nettype none

package rvv_alu_pkg;

  // vector register width in bits
  localparam int VLEN        = 64;
  // number of alu lanes in the cluster
  localparam int NUM_ALU     = 2;
  localparam int QUEUE_DEPTH = 8;
  localparam int ROB_DEPTH   = 8;
  localparam int ROB_IDX_W   = 3;

  // queue pointer and occupancy widths
  localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
  localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);

  // element counts per sew
  localparam int NUM_B       = VLEN / 8;
  localparam int NUM_H       = VLEN / 16;
  localparam int NUM_W       = VLEN / 32;

  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_AND,
    OP_OR,
    OP_XOR
  } alu_op_e;

  // element width select
  typedef enum logic [1:0] {
    SEW8,
    SEW16,
    SEW32
  } sew_e;

  // one vector word, viewed as bytes, halfwords or words
  typedef union packed {
    logic [NUM_B-1:0][7:0]  e8;
    logic [NUM_H-1:0][15:0] e16;
    logic [NUM_W-1:0][31:0] e32;
  } vreg_u;

  // micro-op as dispatched into the queue
  typedef struct packed {
    alu_op_e              op;
    sew_e                 sew;
    // second operand or shift amount
    vreg_u                vs1;
    // first operand
    vreg_u                vs2;
    logic [ROB_IDX_W-1:0] rob_idx;
  } alu_uop_t;

  // lane result headed for the rob
  typedef struct packed {
    logic [ROB_IDX_W-1:0] rob_idx;
    vreg_u                vd;
  } alu_res_t;

endpackage

`default_nettype wire
